//--- filelist.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_exception_regs.sv
logic/csr_interrupt.sv
logic/csr_timer.sv
logic/csr_scratch_regs.sv
logic/csr_read_mux.sv
logic/csr_file.sv
testbench/csr_file_tb.sv

//--- logic/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// register numbers
`define CSR_CRMD         14'h0000
`define CSR_PRMD         14'h0001
`define CSR_ECFG         14'h0004
`define CSR_ESTAT        14'h0005
`define CSR_ERA          14'h0006
`define CSR_BADV         14'h0007
`define CSR_EENTRY       14'h000c
`define CSR_SAVE0        14'h0030
`define CSR_SAVE1        14'h0031
`define CSR_SAVE2        14'h0032
`define CSR_SAVE3        14'h0033
`define CSR_TID          14'h0040
`define CSR_TCFG         14'h0041
`define CSR_TVAL         14'h0042
`define CSR_TICLR        14'h0044

// address error causes
`define ECODE_ADE        6'h08
`define ECODE_ALE        6'h09
`define ESUBCODE_ADEF    9'h000

// field positions
`define CSR_CRMD_PLV     1:0
`define CSR_CRMD_IE      2
`define CSR_CRMD_DA      3
`define CSR_CRMD_PG      4
`define CSR_CRMD_DATF    6:5
`define CSR_CRMD_DATM    8:7
`define CSR_PRMD_PPLV    1:0
`define CSR_PRMD_PIE     2
`define CSR_ESTAT_IS     1:0
`define CSR_ECFG_LIE     12:0
`define CSR_EENTRY_VA    31:6
`define CSR_TCFG_EN      0
`define CSR_TCFG_PERIOD  1
`define CSR_TCFG_INITVAL 31:2
`define CSR_TICLR_CLR    0

// interrupt widths
`define CSR_INT_NUM      13
`define CSR_TIMER_BIT    11
`define CSR_HW_INT_NUM   8

`endif

//--- logic/csr_exception_regs.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_exception_regs import csr_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        csr_we,
    input  csr_num_t   csr_wnum,
    input  csr_word_t  csr_wvalue,
    input  csr_word_t  csr_wmask,
    input  wire        wb_ex,
    input  wire        ertn_flush,
    input  csr_word_t  wb_pc,
    input  csr_word_t  wb_vaddr,
    input  ecode_t     wb_ecode,
    input  esubcode_t  wb_esubcode,
    output plv_t       crmd_plv,
    output logic       crmd_ie,
    output logic       crmd_da,
    output logic       crmd_pg,
    output logic [1:0] crmd_datf,
    output logic [1:0] crmd_datm,
    output plv_t       prmd_pplv,
    output logic       prmd_pie,
    output ecode_t     estat_ecode,
    output esubcode_t  estat_esubcode,
    output csr_word_t  era_pc,
    output csr_word_t  badv_vaddr,
    output logic [25:0] eentry_va,
    output csr_word_t  ex_ra,
    output csr_word_t  ex_entry
);

    csr_word_t crmd_next;
    csr_word_t prmd_next;
    csr_word_t era_next;
    csr_word_t badv_next;
    csr_word_t eentry_next;
    logic      addr_err;

    assign crmd_next = csr_merge({23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie,
                                  crmd_plv}, csr_wvalue, csr_wmask);
    assign prmd_next   = csr_merge({29'b0, prmd_pie, prmd_pplv}, csr_wvalue, csr_wmask);
    assign era_next    = csr_merge(era_pc, csr_wvalue, csr_wmask);
    assign badv_next   = csr_merge(badv_vaddr, csr_wvalue, csr_wmask);
    assign eentry_next = csr_merge({eentry_va, 6'b0}, csr_wvalue, csr_wmask);

    assign addr_err = (wb_ecode == `ECODE_ADE) || (wb_ecode == `ECODE_ALE);

    // plv and ie: exception entry beats return beats software
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_wnum == `CSR_CRMD) begin
            crmd_plv <= crmd_next[`CSR_CRMD_PLV];
            crmd_ie  <= crmd_next[`CSR_CRMD_IE];
        end
    end

    // boots in direct address mode
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (csr_we && csr_wnum == `CSR_CRMD) begin
            crmd_da   <= crmd_next[`CSR_CRMD_DA];
            crmd_pg   <= crmd_next[`CSR_CRMD_PG];
            crmd_datf <= crmd_next[`CSR_CRMD_DATF];
            crmd_datm <= crmd_next[`CSR_CRMD_DATM];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            era_pc         <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            badv_vaddr     <= '0;
            eentry_va      <= '0;
        end else begin
            if (wb_ex) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (csr_we && csr_wnum == `CSR_PRMD) begin
                prmd_pplv <= prmd_next[`CSR_PRMD_PPLV];
                prmd_pie  <= prmd_next[`CSR_PRMD_PIE];
            end

            if (wb_ex) begin
                era_pc         <= wb_pc;
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end else if (csr_we && csr_wnum == `CSR_ERA) begin
                era_pc <= era_next;
            end

            // fetch faults report the pc itself
            if (wb_ex && addr_err) begin
                badv_vaddr <= (wb_ecode == `ECODE_ADE && wb_esubcode == `ESUBCODE_ADEF) ?
                              wb_pc : wb_vaddr;
            end else if (csr_we && csr_wnum == `CSR_BADV) begin
                badv_vaddr <= badv_next;
            end

            if (csr_we && csr_wnum == `CSR_EENTRY) begin
                eentry_va <= eentry_next[`CSR_EENTRY_VA];
            end
        end
    end

    assign ex_ra    = era_pc;
    assign ex_entry = {eentry_va, 6'b0};

    // pipeline never flushes for entry and return at once
    a_ex_ertn_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(wb_ex && ertn_flush));

endmodule

`default_nettype wire

//--- logic/csr_file.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_file import csr_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        csr_we,
    input  csr_num_t   csr_wnum,
    input  csr_word_t  csr_wvalue,
    input  csr_word_t  csr_wmask,
    input  csr_num_t   csr_rnum,
    output csr_word_t  csr_rvalue,
    input  wire        wb_ex,
    input  wire        ertn_flush,
    input  csr_word_t  wb_pc,
    input  csr_word_t  wb_vaddr,
    input  ecode_t     wb_ecode,
    input  esubcode_t  wb_esubcode,
    input  wire [`CSR_HW_INT_NUM-1:0] hw_int_in,
    input  wire        ipi_int_in,
    output csr_word_t  ex_ra,
    output csr_word_t  ex_entry,
    output logic       has_int,
    output stable_cnt_t stable_cnt,
    output csr_word_t  stable_cnt_tid
);

    plv_t        crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    csr_word_t   era_pc;
    csr_word_t   badv_vaddr;
    logic [25:0] eentry_va;
    int_vec_t    estat_is;
    int_vec_t    ecfg_lie;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   timer_cnt;
    logic        timer_pending;
    csr_word_t   save0;
    csr_word_t   save1;
    csr_word_t   save2;
    csr_word_t   save3;

    csr_exception_regs u_exception (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_wnum(csr_wnum), .csr_wvalue(csr_wvalue), .csr_wmask(csr_wmask),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_pc(wb_pc), .wb_vaddr(wb_vaddr),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .crmd_da(crmd_da), .crmd_pg(crmd_pg),
        .crmd_datf(crmd_datf), .crmd_datm(crmd_datm),
        .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie),
        .estat_ecode(estat_ecode), .estat_esubcode(estat_esubcode),
        .era_pc(era_pc), .badv_vaddr(badv_vaddr), .eentry_va(eentry_va),
        .ex_ra(ex_ra), .ex_entry(ex_entry)
    );

    csr_interrupt u_interrupt (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_wnum(csr_wnum), .csr_wvalue(csr_wvalue), .csr_wmask(csr_wmask),
        .hw_int_in(hw_int_in), .ipi_int_in(ipi_int_in),
        .timer_pending(timer_pending), .crmd_ie(crmd_ie),
        .estat_is(estat_is), .ecfg_lie(ecfg_lie), .has_int(has_int)
    );

    csr_timer u_timer (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_wnum(csr_wnum), .csr_wvalue(csr_wvalue), .csr_wmask(csr_wmask),
        .tcfg_en(tcfg_en), .tcfg_periodic(tcfg_periodic), .tcfg_initval(tcfg_initval),
        .timer_cnt(timer_cnt), .timer_pending(timer_pending), .stable_cnt(stable_cnt)
    );

    // thread id doubles as the stable counter id
    csr_scratch_regs u_scratch (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_wnum(csr_wnum), .csr_wvalue(csr_wvalue), .csr_wmask(csr_wmask),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(stable_cnt_tid)
    );

    csr_read_mux u_read_mux (
        .clk(clk), .reset(reset), .csr_rnum(csr_rnum),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .crmd_da(crmd_da), .crmd_pg(crmd_pg),
        .crmd_datf(crmd_datf), .crmd_datm(crmd_datm),
        .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie),
        .estat_is(estat_is), .ecfg_lie(ecfg_lie),
        .estat_ecode(estat_ecode), .estat_esubcode(estat_esubcode),
        .era_pc(era_pc), .badv_vaddr(badv_vaddr), .eentry_va(eentry_va),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(stable_cnt_tid),
        .tcfg_en(tcfg_en), .tcfg_periodic(tcfg_periodic), .tcfg_initval(tcfg_initval),
        .timer_cnt(timer_cnt),
        .csr_rvalue(csr_rvalue)
    );

endmodule

`default_nettype wire

//--- logic/csr_interrupt.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_interrupt import csr_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        csr_we,
    input  csr_num_t   csr_wnum,
    input  csr_word_t  csr_wvalue,
    input  csr_word_t  csr_wmask,
    input  wire [`CSR_HW_INT_NUM-1:0] hw_int_in,
    input  wire        ipi_int_in,
    input  wire        timer_pending,
    input  wire        crmd_ie,
    output int_vec_t   estat_is,
    output int_vec_t   ecfg_lie,
    output logic       has_int
);

    logic [1:0]                sw_is;
    logic [`CSR_HW_INT_NUM-1:0] hw_is;
    logic                      ipi_is;
    csr_word_t                 estat_next;
    csr_word_t                 ecfg_next;

    assign estat_next = csr_merge(csr_word_t'(estat_is), csr_wvalue, csr_wmask);
    assign ecfg_next  = csr_merge(csr_word_t'(ecfg_lie), csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            sw_is    <= '0;
            hw_is    <= '0;
            ipi_is   <= 1'b0;
            ecfg_lie <= '0;
        end else begin
            if (csr_we && csr_wnum == `CSR_ESTAT) begin
                sw_is <= estat_next[`CSR_ESTAT_IS];
            end
            if (csr_we && csr_wnum == `CSR_ECFG) begin
                ecfg_lie <= ecfg_next[`CSR_ECFG_LIE];
            end
            // lines sampled one cycle late
            hw_is  <= hw_int_in;
            ipi_is <= ipi_int_in;
        end
    end

    // bit 10 reserved
    assign estat_is = {ipi_is, timer_pending, 1'b0, hw_is, sw_is};

    assign has_int = (|(estat_is[`CSR_TIMER_BIT:0] & ecfg_lie[`CSR_TIMER_BIT:0])) && crmd_ie;

endmodule

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [`CSR_INT_NUM-1:0] int_vec_t;
    typedef logic [63:0] stable_cnt_t;

    // take new bits where mask is set, keep old ones elsewhere
    function automatic csr_word_t csr_merge(
        input csr_word_t old_value,
        input csr_word_t new_value,
        input csr_word_t mask
    );
        return (mask & new_value) | (~mask & old_value);
    endfunction

endpackage

`default_nettype wire

//--- logic/csr_read_mux.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_read_mux import csr_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  csr_num_t    csr_rnum,
    input  plv_t        crmd_plv,
    input  wire         crmd_ie,
    input  wire         crmd_da,
    input  wire         crmd_pg,
    input  wire  [1:0]  crmd_datf,
    input  wire  [1:0]  crmd_datm,
    input  plv_t        prmd_pplv,
    input  wire         prmd_pie,
    input  int_vec_t    estat_is,
    input  int_vec_t    ecfg_lie,
    input  ecode_t      estat_ecode,
    input  esubcode_t   estat_esubcode,
    input  csr_word_t   era_pc,
    input  csr_word_t   badv_vaddr,
    input  wire  [25:0] eentry_va,
    input  csr_word_t   save0,
    input  csr_word_t   save1,
    input  csr_word_t   save2,
    input  csr_word_t   save3,
    input  csr_word_t   tid,
    input  wire         tcfg_en,
    input  wire         tcfg_periodic,
    input  wire  [29:0] tcfg_initval,
    input  csr_word_t   timer_cnt,
    output csr_word_t   csr_rvalue
);

    always_comb begin
        case (csr_rnum)
            `CSR_CRMD:   csr_rvalue = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da,
                                       crmd_ie, crmd_plv};
            `CSR_PRMD:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            `CSR_ECFG:   csr_rvalue = {19'b0, ecfg_lie};
            `CSR_ESTAT:  csr_rvalue = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            `CSR_ERA:    csr_rvalue = era_pc;
            `CSR_BADV:   csr_rvalue = badv_vaddr;
            `CSR_EENTRY: csr_rvalue = {eentry_va, 6'b0};
            `CSR_SAVE0:  csr_rvalue = save0;
            `CSR_SAVE1:  csr_rvalue = save1;
            `CSR_SAVE2:  csr_rvalue = save2;
            `CSR_SAVE3:  csr_rvalue = save3;
            `CSR_TID:    csr_rvalue = tid;
            `CSR_TCFG:   csr_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
            `CSR_TVAL:   csr_rvalue = timer_cnt;
            // write-only clear
            `CSR_TICLR:  csr_rvalue = '0;
            default:     csr_rvalue = '0;
        endcase
    end

    a_rvalue_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(csr_rvalue));

endmodule

`default_nettype wire

//--- logic/csr_scratch_regs.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_scratch_regs import csr_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       csr_we,
    input  csr_num_t  csr_wnum,
    input  csr_word_t csr_wvalue,
    input  csr_word_t csr_wmask,
    output csr_word_t save0,
    output csr_word_t save1,
    output csr_word_t save2,
    output csr_word_t save3,
    output csr_word_t tid
);

    csr_word_t save_q [4];

    // save registers sit at consecutive numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset) begin
                save_q[i] <= '0;
            end else if (csr_we && csr_wnum == csr_num_t'(`CSR_SAVE0 + i)) begin
                save_q[i] <= csr_merge(save_q[i], csr_wvalue, csr_wmask);
            end
        end
    end

    // single core, id zero
    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (csr_we && csr_wnum == `CSR_TID) begin
            tid <= csr_merge(tid, csr_wvalue, csr_wmask);
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

`default_nettype wire

//--- logic/csr_timer.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_timer import csr_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         csr_we,
    input  csr_num_t    csr_wnum,
    input  csr_word_t   csr_wvalue,
    input  csr_word_t   csr_wmask,
    output logic        tcfg_en,
    output logic        tcfg_periodic,
    output logic [29:0] tcfg_initval,
    output csr_word_t   timer_cnt,
    output logic        timer_pending,
    output stable_cnt_t stable_cnt
);

    csr_word_t tcfg_next;
    logic      tcfg_wr;
    logic      ticlr_wr;

    assign tcfg_wr   = csr_we && csr_wnum == `CSR_TCFG;
    assign ticlr_wr  = csr_we && csr_wnum == `CSR_TICLR;
    assign tcfg_next = csr_merge({tcfg_initval, tcfg_periodic, tcfg_en}, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_wr) begin
            tcfg_en       <= tcfg_next[`CSR_TCFG_EN];
            tcfg_periodic <= tcfg_next[`CSR_TCFG_PERIOD];
            tcfg_initval  <= tcfg_next[`CSR_TCFG_INITVAL];
        end
    end

    // all ones means idle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= '1;
        end else if (tcfg_wr && tcfg_next[`CSR_TCFG_EN]) begin
            timer_cnt <= {tcfg_next[`CSR_TCFG_INITVAL], 2'b0};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_pending <= 1'b1;
        end else if (ticlr_wr && csr_wvalue[`CSR_TICLR_CLR] && csr_wmask[`CSR_TICLR_CLR]) begin
            timer_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    a_cnt_idle_when_off: assert property (@(posedge clk) disable iff (reset)
        !tcfg_en && !(tcfg_wr && tcfg_next[`CSR_TCFG_EN]) |=> timer_cnt == $past(timer_cnt));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the csr_file testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module csr_file_tb -f filelist.f -o csr_sim

# the log decides the result
./obj_dir/csr_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    exit 0
else
    exit 1
fi

//--- testbench/csr_file_tb.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_file_tb import csr_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        csr_we;
    csr_num_t    csr_wnum;
    csr_word_t   csr_wvalue;
    csr_word_t   csr_wmask;
    csr_num_t    csr_rnum;
    csr_word_t   csr_rvalue;
    logic        wb_ex;
    logic        ertn_flush;
    csr_word_t   wb_pc;
    csr_word_t   wb_vaddr;
    ecode_t      wb_ecode;
    esubcode_t   wb_esubcode;
    logic [`CSR_HW_INT_NUM-1:0] hw_int_in;
    logic        ipi_int_in;
    csr_word_t   ex_ra;
    csr_word_t   ex_entry;
    logic        has_int;
    stable_cnt_t stable_cnt;
    csr_word_t   stable_cnt_tid;

    integer      seed;
    int          cycles;
    csr_word_t   save_model [4];
    csr_word_t   tid_model;
    csr_word_t   entry_model;

    csr_file dut (
        .clk(clk), .reset(reset),
        .csr_we(csr_we), .csr_wnum(csr_wnum), .csr_wvalue(csr_wvalue), .csr_wmask(csr_wmask),
        .csr_rnum(csr_rnum), .csr_rvalue(csr_rvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_pc(wb_pc), .wb_vaddr(wb_vaddr),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode),
        .hw_int_in(hw_int_in), .ipi_int_in(ipi_int_in),
        .ex_ra(ex_ra), .ex_entry(ex_entry), .has_int(has_int),
        .stable_cnt(stable_cnt), .stable_cnt_tid(stable_cnt_tid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input csr_word_t actual, input csr_word_t expected,
                              input string what);
        assert (actual === expected)
        else stop_with_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                       $time, what, actual, expected));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // combinational read sampled mid-cycle
    task automatic read_and_compare(input csr_num_t num, input csr_word_t expected,
                                    input string what);
        csr_rnum = num;
        @(negedge clk);
        check_word(csr_rvalue, expected, what);
        next_cycle();
    endtask

    task automatic write_csr(input csr_num_t num, input csr_word_t value,
                             input csr_word_t mask);
        csr_we     = 1'b1;
        csr_wnum   = num;
        csr_wvalue = value;
        csr_wmask  = mask;
        next_cycle();
        csr_we = 1'b0;
    endtask

    task automatic raise_exception(input csr_word_t pc, input csr_word_t vaddr,
                                   input ecode_t ecode, input esubcode_t esubcode);
        wb_ex       = 1'b1;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        wb_ecode    = ecode;
        wb_esubcode = esubcode;
        next_cycle();
        wb_ex = 1'b0;
    endtask

    task automatic return_from_exception();
        ertn_flush = 1'b1;
        next_cycle();
        ertn_flush = 1'b0;
    endtask

    a_stable_steps: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> stable_cnt == $past(stable_cnt) + 64'd1)
        else stop_with_error($sformatf("mismatch at %0t: stable counter did not step by one",
                                       $time));

    // the full run needs a few hundred cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 2000) begin
            stop_with_error("timeout: the run did not finish within 2000 cycles");
        end
    end

    initial begin
        csr_word_t   value;
        csr_word_t   mask;
        csr_word_t   pc;
        csr_word_t   vaddr;
        csr_word_t   quad;
        csr_word_t   cause;
        logic [29:0] n;
        logic [2:0]  line;
        stable_cnt_t t0;
        int          idx;
        int          k;

        seed        = 48802;
        reset       = 1'b1;
        csr_we      = 1'b0;
        csr_wnum    = '0;
        csr_wvalue  = '0;
        csr_wmask   = '0;
        csr_rnum    = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        save_model  = '{default: '0};
        tid_model   = '0;
        entry_model = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        assert (stable_cnt === 64'd0)
        else stop_with_error($sformatf("mismatch at %0t: stable_cnt after reset is %h",
                                       $time, stable_cnt));
        check_word({31'b0, has_int}, 32'd0, "has_int after reset");
        read_and_compare(`CSR_CRMD, 32'h8, "crmd after reset");
        read_and_compare(`CSR_TVAL, 32'hffff_ffff, "tval after reset");

        // masked writes visit each register twice
        for (int i = 0; i < 12; i++) begin
            idx   = i % 6;
            value = $random(seed);
            mask  = $random(seed);
            if (idx < 4) begin
                save_model[idx[1:0]] = (save_model[idx[1:0]] & ~mask) | (value & mask);
                write_csr(csr_num_t'(`CSR_SAVE0 + idx), value, mask);
                read_and_compare(csr_num_t'(`CSR_SAVE0 + idx), save_model[idx[1:0]], "save");
            end else if (idx == 4) begin
                tid_model = (tid_model & ~mask) | (value & mask);
                write_csr(`CSR_TID, value, mask);
                read_and_compare(`CSR_TID, tid_model, "tid");
                check_word(stable_cnt_tid, tid_model, "stable_cnt_tid");
            end else begin
                entry_model = ((entry_model & ~mask) | (value & mask)) & 32'hffff_ffc0;
                write_csr(`CSR_EENTRY, value, mask);
                read_and_compare(`CSR_EENTRY, entry_model, "eentry");
                check_word(ex_entry, entry_model, "ex_entry");
            end
        end

        // misaligned load from plv 3 with interrupts on
        write_csr(`CSR_CRMD, 32'h7, 32'h7);
        read_and_compare(`CSR_CRMD, 32'hf, "crmd before exception");
        pc    = $random(seed) & 32'hffff_fffc;
        vaddr = $random(seed);
        raise_exception(pc, vaddr, `ECODE_ALE, 9'h0);
        check_word(ex_ra, pc, "ex_ra");
        read_and_compare(`CSR_ERA, pc, "era");
        read_and_compare(`CSR_CRMD, 32'h8, "crmd after exception");
        read_and_compare(`CSR_PRMD, 32'h7, "prmd after exception");
        read_and_compare(`CSR_ESTAT, csr_word_t'(`ECODE_ALE) << 16, "estat for ale");
        read_and_compare(`CSR_BADV, vaddr, "badv for ale");
        return_from_exception();
        read_and_compare(`CSR_CRMD, 32'hf, "crmd after return");

        // fetch address error from plv 2 reports the pc
        write_csr(`CSR_CRMD, 32'h6, 32'h7);
        read_and_compare(`CSR_CRMD, 32'he, "crmd before second exception");
        pc    = $random(seed);
        vaddr = $random(seed);
        cause = (csr_word_t'(`ESUBCODE_ADEF) << 22) | (csr_word_t'(`ECODE_ADE) << 16);
        raise_exception(pc, vaddr, `ECODE_ADE, `ESUBCODE_ADEF);
        check_word(ex_ra, pc, "ex_ra");
        read_and_compare(`CSR_ESTAT, cause, "estat for adef");
        read_and_compare(`CSR_BADV, pc, "badv for adef");
        read_and_compare(`CSR_PRMD, 32'h6, "prmd after second exception");
        return_from_exception();
        read_and_compare(`CSR_CRMD, 32'he, "crmd after second return");

        // hardware line n sits at status bit n + 2
        line = 3'($random(seed));
        hw_int_in[line] = 1'b1;
        next_cycle();
        check_word({31'b0, has_int}, 32'd0, "has_int without local enable");
        write_csr(`CSR_ECFG, 32'h1 << (line + 2), 32'h1fff);
        check_word({31'b0, has_int}, 32'd1, "has_int with local enable");
        hw_int_in = '0;
        next_cycle();
        check_word({31'b0, has_int}, 32'd0, "has_int after line drops");
        hw_int_in[line] = 1'b1;
        check_word({31'b0, has_int}, 32'd0, "has_int in the cycle the line rises");
        next_cycle();
        check_word({31'b0, has_int}, 32'd1, "has_int one cycle after the line");
        write_csr(`CSR_CRMD, 32'h0, 32'h4);
        check_word({31'b0, has_int}, 32'd0, "has_int with crmd.ie clear");
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        check_word({31'b0, has_int}, 32'd1, "has_int with crmd.ie set again");
        hw_int_in = '0;
        next_cycle();
        check_word({31'b0, has_int}, 32'd0, "has_int after second drop");
        write_csr(`CSR_ECFG, 32'h0, 32'h1fff);

        // one-shot timer
        n    = 30'(3 + $unsigned($random(seed)) % 4);
        quad = {n, 2'b00};
        write_csr(`CSR_TCFG, {n, 2'b01}, 32'hffff_ffff);
        for (k = 0; k <= int'(quad); k++) begin
            read_and_compare(`CSR_TVAL, quad - csr_word_t'(k), "one-shot count");
        end
        read_and_compare(`CSR_TVAL, 32'hffff_ffff, "one-shot count stopped");
        read_and_compare(`CSR_TVAL, 32'hffff_ffff, "one-shot count still stopped");
        read_and_compare(`CSR_ESTAT, cause | 32'h800, "timer pending");
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        read_and_compare(`CSR_ESTAT, cause, "timer pending cleared");

        // periodic timer
        write_csr(`CSR_TCFG, {n, 2'b11}, 32'hffff_ffff);
        for (k = 0; k <= int'(quad); k++) begin
            read_and_compare(`CSR_TVAL, quad - csr_word_t'(k), "periodic count");
        end
        read_and_compare(`CSR_TVAL, quad, "periodic reload");
        read_and_compare(`CSR_ESTAT, cause | 32'h800, "periodic timer pending");
        write_csr(`CSR_TCFG, 32'h0, 32'h1);

        // stable counter over a random gap
        t0 = stable_cnt;
        k  = 5 + int'($unsigned($random(seed)) % 10);
        repeat (k) next_cycle();
        assert (stable_cnt - t0 === 64'(k))
        else stop_with_error($sformatf("mismatch at %0t: stable_cnt moved by %0d in %0d cycles",
                                       $time, stable_cnt - t0, k));
        check_word(stable_cnt_tid, tid_model, "stable_cnt_tid at the end");

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
